// ==== source/lpi_pkg.sv ====
// LPI memory subsystem package
// Widths, bank geometry, response codes and the channel structs that
// are shared by the AXI bridge and the banked memory behind it

`default_nettype none

package lpi_pkg;

  // *********************************************************************
  // Widths and geometry
  // *********************************************************************
  localparam int ADDR_W     = 16;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = 4;
  localparam int ID_W       = 4;
  localparam int NUM_BANK   = 4;
  localparam int BANK_WORDS = 16;
  localparam int MEM_BYTES  = 256;
  localparam int FIFO_DEPTH = 3;

  localparam int BANK_SEL_W = $clog2(NUM_BANK);
  localparam int WORD_IDX_W = $clog2(BANK_WORDS);
  // Counter wide enough to hold 0..FIFO_DEPTH
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [ID_W-1:0]       axi_id_t;
  typedef logic [1:0]            resp_t;
  typedef logic [BANK_SEL_W-1:0] bank_sel_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // *********************************************************************
  // AXI channel payloads
  // *********************************************************************
  typedef struct packed {axi_id_t id; addr_t addr;} axi_ar_t;
  typedef struct packed {axi_id_t id; addr_t addr;} axi_aw_t;
  typedef struct packed {data_t data; strb_t strb;} axi_w_t;
  typedef struct packed {axi_id_t id; data_t data; resp_t resp;} axi_r_t;
  typedef struct packed {axi_id_t id; resp_t resp;} axi_b_t;

  // Request and response packets
  typedef struct packed {
    axi_id_t id;
    logic    write;
    addr_t   addr;
    strb_t   strb;
    data_t   wdata;
  } lpi_req_t;

  typedef struct packed {
    logic    write;
    axi_id_t id;
    resp_t   resp;
    data_t   data;
  } lpi_rsp_t;

  // Last winner of the read/write arbiter
  typedef enum logic {GRANT_READ, GRANT_WRITE} grant_t;

endpackage

`default_nettype wire

// ==== source/lpi_rsp_fifo.sv ====
// LPI response FIFO
// Small circular buffer for response packets. The head entry is
// presented directly and the number of free slots is reported for
// credit tracking.

`timescale 1ns/1ps
`default_nettype none

module lpi_rsp_fifo import lpi_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              push,
  input  wire lpi_rsp_t          push_data,
  input  wire logic              pop,
  output lpi_rsp_t               head,
  output logic                   not_empty,
  output logic [FIFO_CNT_W-1:0]  free_slots
);

  lpi_rsp_t              entries [FIFO_DEPTH];
  logic [FIFO_CNT_W-1:0] wr_ptr;
  logic [FIFO_CNT_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  do_pop;

  assign do_pop     = pop & not_empty;
  assign not_empty  = count != '0;
  assign free_slots = FIFO_CNT_W'(FIFO_DEPTH) - count;
  assign head       = entries[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at FIFO_DEPTH, which need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == FIFO_CNT_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == FIFO_CNT_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + FIFO_CNT_W'(push) - FIFO_CNT_W'(do_pop);
    end
  end

endmodule

`default_nettype wire

// ==== source/axi_lpi_bridge.sv ====
// AXI to LPI bridge
// Arbitrates AR against joined AW/W, packs the winner into one request
// packet and routes returning responses from a small FIFO onto R or B.
// Requests are only issued while the FIFO has room for every response
// still in flight.

`timescale 1ns/1ps
`default_nettype none

module axi_lpi_bridge import lpi_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     ar_valid,
  input  wire axi_ar_t  ar,
  output logic          ar_ready,
  input  wire logic     aw_valid,
  input  wire axi_aw_t  aw,
  output logic          aw_ready,
  input  wire logic     w_valid,
  input  wire axi_w_t   w,
  output logic          w_ready,
  output logic          r_valid,
  output axi_r_t        r,
  input  wire logic     r_ready,
  output logic          b_valid,
  output axi_b_t        b,
  input  wire logic     b_ready,
  output logic          req_valid,
  output lpi_req_t      req,
  input  wire logic     rsp_valid,
  input  wire lpi_rsp_t rsp
);

  grant_t                last_grant;
  logic [FIFO_CNT_W-1:0] inflight;
  logic [FIFO_CNT_W-1:0] free_slots;
  logic                  can_issue;
  logic                  wr_pend;
  logic                  rd_win;
  logic                  fifo_pop;
  logic                  fifo_not_empty;
  lpi_rsp_t              head;

  // *********************************************************************
  // Arbitration and request packing
  // *********************************************************************
  assign can_issue = free_slots > inflight;
  assign wr_pend   = aw_valid & w_valid;
  // Read wins unless a write is pending and read won last time
  assign rd_win    = ar_valid & (~wr_pend | (last_grant == GRANT_WRITE));

  assign ar_ready  = can_issue & (~wr_pend | (last_grant == GRANT_WRITE));
  assign aw_ready  = can_issue & wr_pend & ~rd_win;
  assign w_ready   = aw_ready;
  assign req_valid = can_issue & (rd_win | wr_pend);

  assign req.id    = rd_win ? ar.id : aw.id;
  assign req.write = ~rd_win;
  assign req.addr  = rd_win ? ar.addr : aw.addr;
  assign req.strb  = w.strb;
  assign req.wdata = w.data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Read side goes first after reset
      last_grant <= GRANT_WRITE;
    end else if (req_valid) begin
      last_grant <= rd_win ? GRANT_READ : GRANT_WRITE;
    end
  end

  // Responses owed by the dispatcher, banks and collector
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight <= '0;
    end else if (req_valid && !rsp_valid) begin
      inflight <= inflight + 1'b1;
    end else if (!req_valid && rsp_valid) begin
      inflight <= inflight - 1'b1;
    end
  end

  // *********************************************************************
  // Response buffering and routing
  // *********************************************************************
  lpi_rsp_fifo rsp_fifo0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (rsp_valid),
    .push_data  (rsp),
    .pop        (fifo_pop),
    .head       (head),
    .not_empty  (fifo_not_empty),
    .free_slots (free_slots)
  );

  assign r_valid  = fifo_not_empty & ~head.write;
  assign b_valid  = fifo_not_empty & head.write;
  assign fifo_pop = (r_valid & r_ready) | (b_valid & b_ready);

  assign r.id   = head.id;
  assign r.data = head.data;
  assign r.resp = head.resp;
  assign b.id   = head.id;
  assign b.resp = head.resp;

endmodule

`default_nettype wire

// ==== source/lpi_dispatch.sv ====
// LPI request dispatcher
// Decodes the bank from the request address and raises the strobe of
// that bank. Requests beyond the memory range get a registered SLVERR
// response instead.

`timescale 1ns/1ps
`default_nettype none

module lpi_dispatch import lpi_pkg::*; (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          req_valid,
  input  wire lpi_req_t      req,
  output logic [NUM_BANK-1:0] bank_valid,
  output lpi_req_t           bank_req,
  output logic               err_valid,
  output lpi_rsp_t           err_rsp
);

  bank_sel_t bank_sel;
  logic      in_range;

  // Banks are interleaved on word address bits
  assign bank_sel = req.addr[2 +: BANK_SEL_W];
  assign in_range = 32'(req.addr) < MEM_BYTES;
  assign bank_req = req;

  always_comb begin
    for (int i = 0; i < NUM_BANK; i++) begin
      bank_valid[i] = req_valid & in_range & (bank_sel == bank_sel_t'(i));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_valid <= 1'b0;
    end else begin
      err_valid <= req_valid & ~in_range;
    end
  end

  always_ff @(posedge clk) begin
    err_rsp.write <= req.write;
    err_rsp.id    <= req.id;
    err_rsp.resp  <= RESP_SLVERR;
    err_rsp.data  <= '0;
  end

endmodule

`default_nettype wire

// ==== source/lpi_mem_bank.sv ====
// LPI memory bank
// Word-addressed storage with byte-strobe writes. Every request gets
// an OKAY response one cycle later with the id echoed.

`timescale 1ns/1ps
`default_nettype none

module lpi_mem_bank import lpi_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     bank_valid,
  input  wire lpi_req_t bank_req,
  output logic          rsp_valid,
  output lpi_rsp_t      rsp
);

  data_t     mem [BANK_WORDS];
  word_idx_t word_idx;

  // Word index sits above the bank select bits
  assign word_idx = bank_req.addr[2 + BANK_SEL_W +: WORD_IDX_W];

  always_ff @(posedge clk) begin
    if (bank_valid && bank_req.write) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (bank_req.strb[i]) begin
          mem[word_idx][8*i +: 8] <= bank_req.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= bank_valid;
    end
  end

  // Writes return zero data
  always_ff @(posedge clk) begin
    if (bank_valid) begin
      rsp.write <= bank_req.write;
      rsp.id    <= bank_req.id;
      rsp.resp  <= RESP_OKAY;
      rsp.data  <= bank_req.write ? '0 : mem[word_idx];
    end
  end

endmodule

`default_nettype wire

// ==== source/lpi_collect.sv ====
// LPI response collector
// Merges the bank responses and the error response into one registered
// stream. At most one source is active in a cycle.

`timescale 1ns/1ps
`default_nettype none

module lpi_collect import lpi_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic [NUM_BANK-1:0] bank_rsp_valid,
  input  wire lpi_rsp_t            bank_rsp [NUM_BANK],
  input  wire logic                err_valid,
  input  wire lpi_rsp_t            err_rsp,
  output logic                     rsp_valid,
  output lpi_rsp_t                 rsp
);

  lpi_rsp_t sel_rsp;

  always_comb begin
    sel_rsp = err_rsp;
    for (int i = 0; i < NUM_BANK; i++) begin
      if (bank_rsp_valid[i]) begin
        sel_rsp = bank_rsp[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= (|bank_rsp_valid) | err_valid;
    end
  end

  always_ff @(posedge clk) begin
    rsp <= sel_rsp;
  end

endmodule

`default_nettype wire

// ==== source/lpi_mem_top.sv ====
// Banked LPI memory behind an AXI slave port
// Joins the AXI bridge, the request dispatcher, the memory banks and
// the response collector

`timescale 1ns/1ps
`default_nettype none

module lpi_mem_top import lpi_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    ar_valid,
  input  wire axi_ar_t ar,
  output logic         ar_ready,
  input  wire logic    aw_valid,
  input  wire axi_aw_t aw,
  output logic         aw_ready,
  input  wire logic    w_valid,
  input  wire axi_w_t  w,
  output logic         w_ready,
  output logic         r_valid,
  output axi_r_t       r,
  input  wire logic    r_ready,
  output logic         b_valid,
  output axi_b_t       b,
  input  wire logic    b_ready
);

  logic                req_valid;
  lpi_req_t            req;
  logic                rsp_valid;
  lpi_rsp_t            rsp;
  logic [NUM_BANK-1:0] bank_valid;
  lpi_req_t            bank_req;
  logic                err_valid;
  lpi_rsp_t            err_rsp;
  logic [NUM_BANK-1:0] bank_rsp_valid;
  lpi_rsp_t            bank_rsp [NUM_BANK];

  axi_lpi_bridge bridge0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .ar_valid  (ar_valid),
    .ar        (ar),
    .ar_ready  (ar_ready),
    .aw_valid  (aw_valid),
    .aw        (aw),
    .aw_ready  (aw_ready),
    .w_valid   (w_valid),
    .w         (w),
    .w_ready   (w_ready),
    .r_valid   (r_valid),
    .r         (r),
    .r_ready   (r_ready),
    .b_valid   (b_valid),
    .b         (b),
    .b_ready   (b_ready),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  lpi_dispatch dispatch0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .bank_valid (bank_valid),
    .bank_req   (bank_req),
    .err_valid  (err_valid),
    .err_rsp    (err_rsp)
  );

  // *********************************************************************
  // Memory banks
  // *********************************************************************
  for (genvar i = 0; i < NUM_BANK; i++) begin : g_bank
    lpi_mem_bank bank0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .bank_valid (bank_valid[i]),
      .bank_req   (bank_req),
      .rsp_valid  (bank_rsp_valid[i]),
      .rsp        (bank_rsp[i])
    );
  end

  lpi_collect collect0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .bank_rsp_valid (bank_rsp_valid),
    .bank_rsp       (bank_rsp),
    .err_valid      (err_valid),
    .err_rsp        (err_rsp),
    .rsp_valid      (rsp_valid),
    .rsp            (rsp)
  );

endmodule

`default_nettype wire

// ==== test/tb_lpi_mem_top.sv ====
// Testbench for the banked LPI memory behind the AXI slave port
// Drives random AXI reads and writes from an LCG, predicts every
// response with a byte model of the memory and checks ids, order,
// response codes, data and the three cycle latency

`timescale 1ns/1ps
`default_nettype none

module tb_lpi_mem_top import lpi_pkg::*; ();

  localparam int RST_CYCLES   = 8;
  localparam int DRV          = 1;
  localparam int N_WR         = 40;
  localparam int N_ERR        = 8;
  localparam int N_LAT        = 4;
  localparam int N_MIX        = 24;
  localparam int N_TXN        = 2 * N_WR + 2 * N_ERR + 2 * N_LAT + 2 * N_MIX;
  localparam int TIMEOUT      = 200 * N_TXN;
  localparam int DRAIN_CYCLES = 16;
  localparam logic [31:0] SEED = 32'hd6f4;

  typedef struct packed {
    axi_id_t     id;
    resp_t       resp;
    data_t       data;
    data_t       mask;
    logic [31:0] cyc;
  } exp_t;

  logic    clk;
  logic    rst_n;
  logic    ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
  logic    r_valid, r_ready, b_valid, b_ready;
  axi_ar_t ar;
  axi_aw_t aw;
  axi_w_t  w;
  axi_r_t  r;
  axi_b_t  b;

  logic [31:0] cycle;
  logic [31:0] stim_state, stall_state, rnd;
  logic        stall_en, stall_now, check_lat;
  int          rd_wait, wr_wait;
  exp_t        rd_exp[$];
  exp_t        wr_exp[$];
  exp_t        acc, head;
  logic [7:0]  mem_model [MEM_BYTES];
  bit          known [MEM_BYTES];
  addr_t       wr_addr [N_WR];
  addr_t       err_addr [N_ERR];
  addr_t       mix_rd_addr [N_MIX];
  addr_t       mix_wr_addr [N_MIX];
  axi_id_t     mix_rd_id [N_MIX];
  axi_id_t     mix_wr_id [N_MIX];
  data_t       mix_wr_data [N_MIX];
  strb_t       mix_wr_strb [N_MIX];

  lpi_mem_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .r_valid  (r_valid),
    .r        (r),
    .r_ready  (r_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // **********************************************************************
  // Helpers
  // **********************************************************************
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = lcg_step(stim_state);
    return stim_state;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("error %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Model word at the address rounded down to a word boundary
  function automatic data_t model_word(input addr_t a);
    int    base;
    data_t d;
    base = int'(a[7:0] & 8'hfc);
    for (int i = 0; i < STRB_W; i++) begin
      d[8*i +: 8] = mem_model[base + i];
    end
    return d;
  endfunction

  // Bytes never written are unknown and left out of the compare
  function automatic data_t model_mask(input addr_t a);
    int    base;
    data_t m;
    base = int'(a[7:0] & 8'hfc);
    for (int i = 0; i < STRB_W; i++) begin
      m[8*i +: 8] = known[base + i] ? 8'hff : 8'h00;
    end
    return m;
  endfunction

  task automatic model_write(input addr_t a, input data_t d, input strb_t s);
    int base;
    base = int'(a[7:0] & 8'hfc);
    for (int i = 0; i < STRB_W; i++) begin
      if (s[i]) begin
        mem_model[base + i] = d[8*i +: 8];
        known[base + i] = 1'b1;
      end
    end
  endtask

  // Both senders start and end at the drive point after a rising edge
  task automatic send_read(input addr_t addr, input axi_id_t id);
    ar_valid = 1'b1;
    ar.id    = id;
    ar.addr  = addr;
    do @(negedge clk); while (!ar_ready);
    @(posedge clk);
    #DRV;
    ar_valid = 1'b0;
  endtask

  task automatic send_write(input addr_t addr, input axi_id_t id,
                            input data_t data, input strb_t strb);
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    aw.id    = id;
    aw.addr  = addr;
    w.data   = data;
    w.strb   = strb;
    do @(negedge clk); while (!aw_ready);
    @(posedge clk);
    #DRV;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
  endtask

  task automatic wait_drain();
    do @(posedge clk); while (rd_exp.size() != 0 || wr_exp.size() != 0);
    #DRV;
  endtask

  // **********************************************************************
  // Cycle count, timeout and ready stalls
  // **********************************************************************
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT) begin
      abort_run($sformatf("timeout, run exceeded %0d cycles", TIMEOUT));
    end
  end

  always begin
    @(posedge clk);
    stall_now = stall_en;
    #DRV;
    if (stall_now) begin
      stall_state = lcg_step(stall_state);
      r_ready = stall_state[20:19] != 2'b00;
      b_ready = stall_state[23:22] != 2'b00;
    end else begin
      r_ready = 1'b1;
      b_ready = 1'b1;
    end
  end

  // **********************************************************************
  // Monitor sampled mid-cycle where everything is settled
  // **********************************************************************
  always @(negedge clk) begin
    if (rst_n) begin
      if ((aw_valid && aw_ready) != (w_valid && w_ready)) begin
        abort_run("AW and W were not accepted in the same cycle");
      end
      if (ar_valid && ar_ready) begin
        acc.id  = ar.id;
        acc.cyc = cycle;
        if (32'(ar.addr) < MEM_BYTES) begin
          acc.resp = RESP_OKAY;
          acc.data = model_word(ar.addr);
          acc.mask = model_mask(ar.addr);
        end else begin
          acc.resp = RESP_SLVERR;
          acc.data = '0;
          acc.mask = '1;
        end
        rd_exp.push_back(acc);
        rd_wait = 0;
        wr_wait = (aw_valid && w_valid) ? wr_wait + 1 : 0;
      end
      if (aw_valid && aw_ready) begin
        acc.id   = aw.id;
        acc.cyc  = cycle;
        acc.data = '0;
        acc.mask = '0;
        if (32'(aw.addr) < MEM_BYTES) begin
          acc.resp = RESP_OKAY;
          model_write(aw.addr, w.data, w.strb);
        end else begin
          acc.resp = RESP_SLVERR;
        end
        wr_exp.push_back(acc);
        wr_wait = 0;
        rd_wait = ar_valid ? rd_wait + 1 : 0;
      end
      if (rd_wait > 2 || wr_wait > 2) begin
        abort_run("arbiter kept one side waiting for more than two grants");
      end
      if (r_valid && r_ready) begin
        if (rd_exp.size() == 0) begin
          abort_run("R response arrived with no read outstanding");
        end else begin
          head = rd_exp.pop_front();
          check_eq("read id", 32'(head.id), 32'(r.id));
          check_eq("read resp", 32'(head.resp), 32'(r.resp));
          check_eq("read data", head.data & head.mask, r.data & head.mask);
          if (check_lat) check_eq("read latency", 32'd3, cycle - head.cyc);
        end
      end
      if (b_valid && b_ready) begin
        if (wr_exp.size() == 0) begin
          abort_run("B response arrived with no write outstanding");
        end else begin
          head = wr_exp.pop_front();
          check_eq("write id", 32'(head.id), 32'(b.id));
          check_eq("write resp", 32'(head.resp), 32'(b.resp));
          if (check_lat) check_eq("write latency", 32'd3, cycle - head.cyc);
        end
      end
    end
  end

  // **********************************************************************
  // Stimulus
  // **********************************************************************
  initial begin
    rst_n       = 1'b0;
    ar_valid    = 1'b0;
    aw_valid    = 1'b0;
    w_valid     = 1'b0;
    ar          = '0;
    aw          = '0;
    w           = '0;
    r_ready     = 1'b1;
    b_ready     = 1'b1;
    cycle       = '0;
    stim_state  = SEED;
    stall_state = SEED;
    stall_en    = 1'b0;
    check_lat   = 1'b0;
    rd_wait     = 0;
    wr_wait     = 0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem_model[i] = 8'h00;
      known[i]     = 1'b0;
    end

    // No response may show up during or right after reset
    repeat (RST_CYCLES) begin
      @(negedge clk);
      check_eq("reset r_valid", 32'd0, 32'(r_valid));
      check_eq("reset b_valid", 32'd0, 32'(b_valid));
    end
    @(posedge clk);
    #DRV;
    rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_eq("idle r_valid", 32'd0, 32'(r_valid));
      check_eq("idle b_valid", 32'd0, 32'(b_valid));
    end
    @(posedge clk);
    #DRV;

    // Random writes to the low half, then read every one back
    stall_en = 1'b1;
    for (int i = 0; i < N_WR; i++) begin
      rnd = next_rand();
      wr_addr[i] = {8'h00, 1'b0, rnd[20:16], 2'b00};
      send_write(wr_addr[i], rnd[31:28], next_rand(), rnd[27:24]);
    end
    wait_drain();
    for (int i = 0; i < N_WR; i++) begin
      rnd = next_rand();
      send_read(wr_addr[i], rnd[31:28]);
    end
    wait_drain();

    // Out of range accesses, then reads of their low aliases
    stall_en = 1'b0;
    for (int i = 0; i < N_ERR; i++) begin
      rnd = next_rand();
      err_addr[i] = {rnd[15:8] | 8'h01, 1'b0, rnd[20:16], 2'b00};
      if (i % 2 == 0) begin
        send_write(err_addr[i], rnd[31:28], next_rand(), 4'hf);
      end else begin
        send_read(err_addr[i], rnd[31:28]);
      end
    end
    wait_drain();
    for (int i = 0; i < N_ERR; i++) begin
      rnd = next_rand();
      send_read({8'h00, err_addr[i][7:0]}, rnd[31:28]);
    end
    wait_drain();

    // One at a time with ready high
    check_lat = 1'b1;
    for (int i = 0; i < N_LAT; i++) begin
      rnd = next_rand();
      send_write({8'h00, rnd[7:2], 2'b00}, rnd[31:28], next_rand(), rnd[27:24]);
      wait_drain();
      send_read({8'h00, rnd[7:2], 2'b00}, rnd[23:20]);
      wait_drain();
    end
    check_lat = 1'b0;

    // Reads of the upper half compete with writes to the lower half
    for (int i = 0; i < N_MIX; i++) begin
      rnd = next_rand();
      mix_rd_addr[i] = {8'h00, 1'b1, rnd[20:16], 2'b00};
      mix_rd_id[i]   = rnd[31:28];
      mix_wr_addr[i] = {8'h00, 1'b0, rnd[12:8], 2'b00};
      mix_wr_id[i]   = rnd[27:24];
      mix_wr_strb[i] = rnd[7:4];
      mix_wr_data[i] = next_rand();
    end
    stall_en = 1'b1;
    fork
      begin
        for (int j = 0; j < N_MIX; j++) send_read(mix_rd_addr[j], mix_rd_id[j]);
      end
      begin
        for (int k = 0; k < N_MIX; k++) begin
          send_write(mix_wr_addr[k], mix_wr_id[k], mix_wr_data[k], mix_wr_strb[k]);
        end
      end
    join

    // With ready high the FIFO and the pipeline empty within a few cycles
    stall_en = 1'b0;
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (rd_exp.size() != 0 || wr_exp.size() != 0) begin
      abort_run("responses still missing at the end of the run");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/lpi_pkg.sv
source/lpi_rsp_fifo.sv
source/axi_lpi_bridge.sv
source/lpi_dispatch.sv
source/lpi_mem_bank.sv
source/lpi_collect.sv
source/lpi_mem_top.sv
test/tb_lpi_mem_top.sv

// ==== Makefile ====
# Verilator build and run for the LPI memory testbench

VERILATOR ?= verilator
TOP       ?= tb_lpi_mem_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
